/* fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// word addresses, fall-through is pc+1
`define PC_W 16
`define INST_W 32

// 64-entry btb, tag is the rest of the pc
`define BTB_IDX_W 6

// local history table and pattern counters
`define LHT_IDX_W 4
`define HIST_W 4

// branches allowed in flight
`define QUEUE_DEPTH 8

`define OPC_BRANCH 7'b1100011
`define OPC_JAL 7'b1101111
`define OPC_JALR 7'b1100111

`endif

/* rv_fetch_pkg.sv */
`include "fetch_settings.svh"

package rv_fetch_pkg;

  typedef logic [`PC_W-1:0] pc_t; // word address
  typedef logic [`INST_W-1:0] inst_t;
  typedef logic [6:0] opcode_t;

  typedef logic [`PC_W-`BTB_IDX_W-1:0] btb_tag_t; // upper pc bits

  typedef logic [`HIST_W-1:0] history_t; // newest outcome in bit 0
  typedef logic [1:0] counter_t; // msb gives taken

  typedef enum logic [1:0]
  {
    IDLE,
    FETCH,
    HOLD
  } fetch_state_e;

endpackage

/* branch_queue.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module branch_queue
  import rv_fetch_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic q_push,
  input  pc_t  push_pc,
  input  pc_t  push_next_pc,
  input  logic push_cond,
  input  logic q_pop,
  input  logic q_flush,
  output logic q_full,
  output logic q_empty,
  output pc_t  head_pc,
  output pc_t  head_next_pc,
  output logic head_cond
);

  localparam int PTR_W = $clog2(`QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

  pc_t pc_mem [`QUEUE_DEPTH];
  pc_t next_mem [`QUEUE_DEPTH];
  logic [`QUEUE_DEPTH-1:0] cond_mem;

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic do_push;
  logic do_pop;

  assign do_push = q_push && !q_flush; // flush drops a same-cycle push
  assign do_pop = q_pop && !q_empty && !q_flush;

  assign q_full = (count == CNT_W'(`QUEUE_DEPTH));
  assign q_empty = (count == '0);

  assign head_pc = pc_mem[rd_ptr];
  assign head_next_pc = next_mem[rd_ptr];
  assign head_cond = cond_mem[rd_ptr];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else if (q_flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      pc_mem[wr_ptr] <= push_pc;
      next_mem[wr_ptr] <= push_next_pc;
      cond_mem[wr_ptr] <= push_cond;
    end
  end

  // fetch must stop before the queue overflows
  assert property (@(posedge clk) disable iff (rst) q_push && q_full |-> q_pop)
    else $error("branch queue push while full");

endmodule

/* btb.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module btb
  import rv_fetch_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  pc_t  lookup_pc,
  input  logic btb_we,
  input  pc_t  upd_pc,
  input  pc_t  upd_target,
  output logic btb_hit,
  output pc_t  btb_target
);

  localparam int ENTRIES = 2 ** `BTB_IDX_W;

  logic [ENTRIES-1:0] valid;
  btb_tag_t tag_mem [ENTRIES];
  pc_t tgt_mem [ENTRIES];

  logic [`BTB_IDX_W-1:0] lk_idx;
  logic [`BTB_IDX_W-1:0] up_idx;
  btb_tag_t lk_tag;
  btb_tag_t up_tag;

  assign lk_idx = lookup_pc[`BTB_IDX_W-1:0];
  assign lk_tag = lookup_pc[`PC_W-1:`BTB_IDX_W];
  assign up_idx = upd_pc[`BTB_IDX_W-1:0];
  assign up_tag = upd_pc[`PC_W-1:`BTB_IDX_W];

  // reads see the table before any same-cycle write
  assign btb_hit = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);
  assign btb_target = tgt_mem[lk_idx];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      valid <= '0;
    else if (btb_we)
      valid[up_idx] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (btb_we)
    begin
      tag_mem[up_idx] <= up_tag;
      tgt_mem[up_idx] <= upd_target; // overwrites any alias
    end
  end

endmodule

/* local_predictor.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module local_predictor
  import rv_fetch_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  pc_t  lookup_pc,
  input  logic pred_we,
  input  pc_t  upd_pc,
  input  logic pred_outcome,
  output logic pred_taken
);

  localparam int LHT_N = 2 ** `LHT_IDX_W;
  localparam int CTR_N = 2 ** `HIST_W;

  history_t lht [LHT_N]; // per-pc history
  counter_t ctr [CTR_N]; // shared, indexed by history

  logic [`LHT_IDX_W-1:0] lk_idx;
  logic [`LHT_IDX_W-1:0] up_idx;
  history_t lk_hist;
  history_t up_hist;
  counter_t up_ctr;

  assign lk_idx = lookup_pc[`LHT_IDX_W-1:0];
  assign up_idx = upd_pc[`LHT_IDX_W-1:0];

  assign lk_hist = lht[lk_idx];
  assign pred_taken = ctr[lk_hist][1];

  assign up_hist = lht[up_idx];
  assign up_ctr = ctr[up_hist];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < LHT_N; i++)
        lht[i] <= '0;
      for (int j = 0; j < CTR_N; j++)
        ctr[j] <= '0;
    end
    else if (pred_we)
    begin
      // saturate at strongly taken / strongly not taken
      if (pred_outcome && (up_ctr != 2'b11))
        ctr[up_hist] <= up_ctr + 2'd1;
      else if (!pred_outcome && (up_ctr != 2'b00))
        ctr[up_hist] <= up_ctr - 2'd1;
      lht[up_idx] <= {up_hist[`HIST_W-2:0], pred_outcome}; // shift in at lsb
    end
  end

endmodule

/* fetch_ctrl.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_ctrl
  import rv_fetch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  inst_t wb_dat_i,
  input  logic  wb_ack,
  input  logic  res_valid,
  input  logic  res_taken,
  input  pc_t   res_target,
  input  logic  btb_hit,
  input  pc_t   btb_target,
  input  logic  pred_taken,
  input  logic  q_full,
  input  logic  q_empty,
  input  pc_t   head_pc,
  input  pc_t   head_next_pc,
  input  logic  head_cond,
  output logic  wb_cyc,
  output logic  wb_stb,
  output pc_t   wb_adr,
  output pc_t   lookup_pc,
  output logic  btb_we,
  output pc_t   upd_pc,
  output pc_t   upd_target,
  output logic  pred_we,
  output logic  pred_outcome,
  output logic  q_push,
  output pc_t   push_pc,
  output pc_t   push_next_pc,
  output logic  push_cond,
  output logic  q_pop,
  output logic  q_flush
);

  localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

  fetch_state_e state;
  fetch_state_e state_nxt;

  pc_t pc;
  pc_t pred_next;
  pc_t actual_next;
  pc_t redirect_pc;
  logic redirect_pend; // redirect waiting for the bus ack
  logic [CNT_W-1:0] inflight; // mirrors queue occupancy

  opcode_t opcode;
  logic is_branch;
  logic is_jump;
  logic take;
  logic resolve;
  logic ack_ok;
  logic accept;
  logic mispredict;
  logic full_next;

  assign wb_cyc = (state == FETCH);
  assign wb_stb = (state == FETCH);
  assign wb_adr = pc;
  assign lookup_pc = pc;

  // prediction on the returned word
  assign opcode = wb_dat_i[6:0];
  assign is_branch = (opcode == `OPC_BRANCH);
  assign is_jump = (opcode == `OPC_JAL) || (opcode == `OPC_JALR);
  assign take = btb_hit && (is_jump || (is_branch && pred_taken));
  assign pred_next = take ? btb_target : pc + pc_t'(1);

  // resolve of the oldest branch
  assign resolve = res_valid && !q_empty;
  assign actual_next = res_taken ? res_target : head_pc + pc_t'(1);
  assign mispredict = resolve && (actual_next != head_next_pc);

  assign q_pop = resolve;
  assign q_flush = mispredict;
  assign btb_we = resolve && res_taken;
  assign upd_pc = head_pc;
  assign upd_target = res_target;
  assign pred_we = resolve && head_cond; // jumps leave the counters alone
  assign pred_outcome = res_taken;

  assign ack_ok = wb_stb && wb_ack;
  assign accept = ack_ok && !redirect_pend && !mispredict; // else word is dropped
  assign q_push = accept && (is_branch || is_jump);
  assign push_pc = pc;
  assign push_next_pc = pred_next;
  assign push_cond = is_branch;

  assign full_next = !q_flush &&
                     ((q_full && !q_pop) ||
                      (q_push && !q_pop && (inflight == CNT_W'(`QUEUE_DEPTH - 1))));

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
        state_nxt = FETCH;
      FETCH:
        if (ack_ok)
          state_nxt = full_next ? HOLD : FETCH;
      HOLD:
        state_nxt = full_next ? HOLD : FETCH; // leaves on pop or flush
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= IDLE;
      pc <= '0;
      redirect_pend <= 1'b0;
      inflight <= '0;
    end
    else
    begin
      state <= state_nxt;

      if (ack_ok)
      begin
        if (mispredict)
          pc <= actual_next;
        else if (redirect_pend)
          pc <= redirect_pc;
        else
          pc <= pred_next;
      end
      else if (mispredict && (state != FETCH))
        pc <= actual_next; // bus idle, take it now

      if (ack_ok)
        redirect_pend <= 1'b0;
      else if (mispredict && (state == FETCH))
        redirect_pend <= 1'b1; // keep wb_adr until the ack

      if (q_flush)
        inflight <= '0;
      else
        inflight <= inflight + CNT_W'(q_push) - CNT_W'(q_pop);
    end
  end

  always_ff @(posedge clk)
  begin
    if (mispredict)
      redirect_pc <= actual_next;
  end

  assert property (@(posedge clk) disable iff (rst) wb_stb && !wb_ack |=> $stable(wb_adr))
    else $error("wb_adr changed before ack");

  // execute may only retire what fetch has queued
  assert property (@(posedge clk) disable iff (rst) res_valid |-> !q_empty)
    else $error("resolve with no branch in flight");

endmodule

/* rv_fetch_top.sv */
`timescale 1ns/1ps

module rv_fetch_top
  import rv_fetch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  inst_t wb_dat_i,
  input  logic  wb_ack,
  input  logic  res_valid,
  input  logic  res_taken,
  input  pc_t   res_target,
  output logic  wb_cyc,
  output logic  wb_stb,
  output pc_t   wb_adr
);

  pc_t lookup_pc;
  logic btb_hit;
  pc_t btb_target;
  logic pred_taken;

  logic btb_we;
  logic pred_we;
  logic pred_outcome;
  pc_t upd_pc;
  pc_t upd_target;

  logic q_push;
  logic q_pop;
  logic q_flush;
  logic q_full;
  logic q_empty;
  pc_t push_pc;
  pc_t push_next_pc;
  logic push_cond;
  pc_t head_pc;
  pc_t head_next_pc;
  logic head_cond;

  fetch_ctrl u_ctrl (
    .clk(clk), .rst(rst), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
    .res_valid(res_valid), .res_taken(res_taken), .res_target(res_target),
    .btb_hit(btb_hit), .btb_target(btb_target), .pred_taken(pred_taken),
    .q_full(q_full), .q_empty(q_empty), .head_pc(head_pc),
    .head_next_pc(head_next_pc), .head_cond(head_cond),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .lookup_pc(lookup_pc),
    .btb_we(btb_we), .upd_pc(upd_pc), .upd_target(upd_target),
    .pred_we(pred_we), .pred_outcome(pred_outcome),
    .q_push(q_push), .push_pc(push_pc), .push_next_pc(push_next_pc),
    .push_cond(push_cond), .q_pop(q_pop), .q_flush(q_flush)
  );

  btb u_btb (
    .clk(clk), .rst(rst), .lookup_pc(lookup_pc), .btb_we(btb_we),
    .upd_pc(upd_pc), .upd_target(upd_target),
    .btb_hit(btb_hit), .btb_target(btb_target)
  );

  local_predictor u_pred (
    .clk(clk), .rst(rst), .lookup_pc(lookup_pc), .pred_we(pred_we),
    .upd_pc(upd_pc), .pred_outcome(pred_outcome), .pred_taken(pred_taken)
  );

  branch_queue u_queue (
    .clk(clk), .rst(rst), .q_push(q_push), .push_pc(push_pc),
    .push_next_pc(push_next_pc), .push_cond(push_cond),
    .q_pop(q_pop), .q_flush(q_flush), .q_full(q_full), .q_empty(q_empty),
    .head_pc(head_pc), .head_next_pc(head_next_pc), .head_cond(head_cond)
  );

endmodule

/* tb_rv_fetch.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module tb_rv_fetch
  import rv_fetch_pkg::*;
();

  localparam int CYCLES = 3000;
  localparam int PROG_N = 64;
  localparam int BTB_N = 2 ** `BTB_IDX_W;
  localparam int STALL_LIMIT = 50;

  logic clk;
  logic rst;
  inst_t wb_dat_i;
  logic wb_ack;
  logic res_valid;
  logic res_taken;
  pc_t res_target;
  logic wb_cyc;
  logic wb_stb;
  pc_t wb_adr;

  inst_t prog [PROG_N];
  pc_t jump_to [PROG_N]; // fixed target per word
  int bias [PROG_N]; // taken odds out of 4

  fetch_state_e m_state;
  pc_t m_pc;
  logic m_pend;
  pc_t m_redir;
  logic [BTB_N-1:0] m_bvalid;
  btb_tag_t m_btag [BTB_N];
  pc_t m_btgt [BTB_N];
  history_t m_lht [2 ** `LHT_IDX_W];
  counter_t m_ctr [2 ** `HIST_W];
  pc_t m_qpc [$];
  pc_t m_qnext [$];
  logic m_qcond [$];

  int wait_cnt;
  int idle_cycles;
  int hold_cycles;
  int trained_hits;
  int pend_redirects;
  logic withhold; // execute holds back resolves
  logic prev_wait;
  pc_t prev_adr;
  logic seen_bus;

  rv_fetch_top dut (
    .clk(clk), .rst(rst), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
    .res_valid(res_valid), .res_taken(res_taken), .res_target(res_target),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("Testbench failed");
    $fatal(1, "%s", why);
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Error %s: got 0x%0h, expected 0x%0h", sig, got, exp);
    stop_with_failure("DUT output differs from the reference model");
  endtask

  task automatic load_program();
    int kind;
    opcode_t opc;
    for (int i = 0; i < PROG_N; i++)
    begin
      kind = $urandom_range(0, 9);
      if (kind < 3)
        opc = `OPC_BRANCH;
      else if (kind == 3)
        opc = `OPC_JAL;
      else if (kind == 4)
        opc = `OPC_JALR;
      else
        opc = 7'b0010011; // op-imm
      prog[i] = {25'($urandom()), opc};
      jump_to[i] = pc_t'($urandom_range(0, PROG_N - 1));
      bias[i] = $urandom_range(0, 4);
    end
  endtask

  task automatic reset_model();
    m_state = IDLE;
    m_pc = '0;
    m_pend = 1'b0;
    m_redir = '0;
    m_bvalid = '0;
    for (int i = 0; i < 2 ** `LHT_IDX_W; i++)
      m_lht[i] = '0;
    for (int i = 0; i < 2 ** `HIST_W; i++)
      m_ctr[i] = '0;
    m_qpc.delete();
    m_qnext.delete();
    m_qcond.delete();
    wait_cnt = $urandom_range(0, 3);
    idle_cycles = 0;
    hold_cycles = 0;
    trained_hits = 0;
    pend_redirects = 0;
    withhold = 1'b0;
    prev_wait = 1'b0;
    prev_adr = '0;
    seen_bus = 1'b0;
  endtask

  task automatic check_outputs();
    logic exp_stb;
    exp_stb = (m_state == FETCH);
    assert (wb_stb === exp_stb) else report_mismatch("wb_stb", 32'(wb_stb), 32'(exp_stb));
    assert (wb_cyc === exp_stb) else report_mismatch("wb_cyc", 32'(wb_cyc), 32'(exp_stb));
    if (exp_stb && !seen_bus)
    begin
      assert (wb_adr === pc_t'(0)) else report_mismatch("wb_adr", 32'(wb_adr), 32'h0);
      seen_bus = 1'b1;
    end
    if (prev_wait)
      assert (wb_adr === prev_adr) else report_mismatch("wb_adr", 32'(wb_adr), 32'(prev_adr));
    if (exp_stb)
      assert (wb_adr === m_pc) else report_mismatch("wb_adr", 32'(wb_adr), 32'(m_pc));
  endtask

  // slave and execute stage drive from the model's view of the next cycle
  task automatic drive_inputs();
    logic valid;
    logic taken;
    logic [5:0] idx;
    rst <= 1'b0;
    wb_dat_i <= prog[m_pc[5:0]];
    if (m_state == FETCH && wait_cnt == 0)
      wb_ack <= 1'b1;
    else
    begin
      wb_ack <= 1'b0;
      if (m_state == FETCH)
        wait_cnt--;
    end
    valid = !withhold && (m_qpc.size() > 0) && ($urandom_range(0, 2) == 0);
    taken = 1'b1; // jumps always go
    idx = '0;
    if (valid)
    begin
      idx = m_qpc[0][5:0];
      if (m_qcond[0])
        taken = ($urandom_range(0, 3) < bias[idx]);
    end
    res_valid <= valid;
    res_taken <= taken;
    res_target <= jump_to[idx];
  endtask

  task automatic step_model();
    logic stb;
    logic ack_ok;
    logic resolve;
    logic mis;
    logic is_br;
    logic is_jmp;
    logic hit;
    logic take;
    logic push;
    logic full_after;
    logic hcond;
    logic [`BTB_IDX_W-1:0] bi;
    logic [`LHT_IDX_W-1:0] li;
    pc_t actual;
    pc_t pnext;
    pc_t hpc;
    pc_t hnext;
    opcode_t opc;
    history_t h;
    stb = (m_state == FETCH);
    ack_ok = stb && wb_ack;
    resolve = res_valid && (m_qpc.size() > 0);
    mis = 1'b0;
    actual = '0;
    hpc = '0;
    hnext = '0;
    hcond = 1'b0;
    if (resolve)
    begin
      hpc = m_qpc[0];
      hnext = m_qnext[0];
      hcond = m_qcond[0];
      actual = res_taken ? res_target : hpc + pc_t'(1);
      mis = (actual != hnext);
    end

    // lookup sees the tables before this cycle's training
    opc = wb_dat_i[6:0];
    is_br = (opc == `OPC_BRANCH);
    is_jmp = (opc == `OPC_JAL) || (opc == `OPC_JALR);
    bi = m_pc[`BTB_IDX_W-1:0];
    hit = m_bvalid[bi] && (m_btag[bi] == m_pc[`PC_W-1:`BTB_IDX_W]);
    take = hit && (is_jmp || (is_br && m_ctr[m_lht[m_pc[`LHT_IDX_W-1:0]]][1]));
    pnext = take ? m_btgt[bi] : m_pc + pc_t'(1);
    push = ack_ok && !m_pend && !mis && (is_br || is_jmp);

    if (resolve)
    begin
      if (!mis && res_taken)
        trained_hits++;
      if (mis && stb && !wb_ack)
        pend_redirects++;
      if (res_taken)
      begin
        m_bvalid[hpc[`BTB_IDX_W-1:0]] = 1'b1;
        m_btag[hpc[`BTB_IDX_W-1:0]] = hpc[`PC_W-1:`BTB_IDX_W];
        m_btgt[hpc[`BTB_IDX_W-1:0]] = res_target;
      end
      if (hcond)
      begin
        li = hpc[`LHT_IDX_W-1:0];
        h = m_lht[li];
        if (res_taken && m_ctr[h] != 2'b11)
          m_ctr[h] = m_ctr[h] + 2'd1;
        else if (!res_taken && m_ctr[h] != 2'b00)
          m_ctr[h] = m_ctr[h] - 2'd1;
        m_lht[li] = {h[`HIST_W-2:0], res_taken};
      end
    end

    if (mis)
    begin
      m_qpc.delete(); // flush loses a same-cycle push
      m_qnext.delete();
      m_qcond.delete();
    end
    else
    begin
      if (resolve)
      begin
        void'(m_qpc.pop_front());
        void'(m_qnext.pop_front());
        void'(m_qcond.pop_front());
      end
      if (push)
      begin
        m_qpc.push_back(m_pc);
        m_qnext.push_back(pnext);
        m_qcond.push_back(is_br);
      end
    end
    full_after = (m_qpc.size() == `QUEUE_DEPTH);

    if (m_state == HOLD)
      hold_cycles++;
    prev_wait = stb && !wb_ack;
    prev_adr = m_pc;

    if (ack_ok)
    begin
      if (mis)
        m_pc = actual;
      else if (m_pend)
        m_pc = m_redir;
      else
        m_pc = pnext;
      m_pend = 1'b0;
      wait_cnt = $urandom_range(0, 3);
    end
    else if (mis && stb)
    begin
      m_pend = 1'b1; // word of this bus cycle gets dropped
      m_redir = actual;
    end
    else if (mis)
      m_pc = actual;

    if (ack_ok || withhold)
      idle_cycles = 0;
    else
      idle_cycles++;

    case (m_state)
      IDLE:
        m_state = FETCH;
      FETCH:
        m_state = (ack_ok && full_after) ? HOLD : FETCH;
      default:
        m_state = full_after ? HOLD : FETCH;
    endcase
  endtask

  initial
  begin
    rst = 1'b1;
    wb_dat_i = '0;
    wb_ack = 1'b0;
    res_valid = 1'b0;
    res_taken = 1'b0;
    res_target = '0;
    void'($urandom(92564));
    load_program();
    reset_model();
    repeat (4)
    begin
      @(posedge clk);
      @(negedge clk);
      check_outputs();
      assert (wb_adr === pc_t'(0)) else report_mismatch("wb_adr", 32'(wb_adr), 32'h0);
    end
    for (int cyc = 0; cyc < CYCLES; cyc++)
    begin
      withhold = (cyc >= 800 && cyc < 1000) || (cyc >= 2000 && cyc < 2200);
      @(posedge clk);
      drive_inputs();
      @(negedge clk);
      check_outputs();
      step_model();
      assert (idle_cycles < STALL_LIMIT)
        else stop_with_failure("no instruction word was accepted for too many cycles");
    end
    assert (trained_hits > 0)
      else stop_with_failure("no taken branch was ever predicted from a trained entry");
    assert (pend_redirects > 0)
      else stop_with_failure("no redirect ever arrived during a bus cycle");
    assert (hold_cycles > 0)
      else stop_with_failure("the branch queue never filled up");
    $display("Testbench passed");
    $finish;
  end

  initial
  begin
    #(20 * (CYCLES + 100));
    stop_with_failure("simulation ran past its cycle budget");
  end

endmodule

/* rv_fetch.f */
+incdir+.
rv_fetch_pkg.sv
branch_queue.sv
btb.sv
local_predictor.sv
fetch_ctrl.sv
rv_fetch_top.sv
tb_rv_fetch.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP := tb_rv_fetch
FILELIST := rv_fetch.f
BUILD_DIR := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
